/* sim.f */
src/wb_pkg.sv
src/ex2_wb_stage.sv
src/exc_commit.sv
src/exc_csr_regs.sv
src/reg_file.sv
src/wb_top.sv
bench/tb_wb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_wb_top
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_wb_top.sv */
`timescale 1ns/1ps
module tb_wb_top;
    import wb_pkg::*;

    typedef struct packed {
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
        int                    due;
    } chk_t;

    typedef struct packed {
        logic [xlen-1:0]   era;
        logic [xlen-1:0]   badv;
        logic [vppn_w-1:0] vppn;
    } csr_state_t;

    logic                  clk;
    logic                  aresetn;
    slot_t                 slot0;
    slot_t                 slot1;
    exc_t                  exc;
    logic [xlen-1:0]       quotient, remainder, csr_data, dcache_data, cfg_data;
    logic                  div_ready, csr_ready, dcache_ready, cpu_interrupt, cfg_we, cfg_sel;
    logic [reg_addr_w-1:0] dcache_rd, rd_addr0, rd_addr1;
    logic                  allowin, flush;
    logic [xlen-1:0]       rd_data0, rd_data1, redirect_pc, era, badv;
    logic [vppn_w-1:0]     vppn;
    chk_t                  chk_q [$];
    int                    cyc;
    csr_state_t            csr_model;
    logic [xlen-1:0]       eentry_v, tlbr_v, target;
    ecode_e                codes [10] = '{ecode_pil, ecode_pis, ecode_pif, ecode_pme,
        ecode_ppi, ecode_adef, ecode_ale, ecode_tlbr, ecode_sys, ecode_int};

    wb_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected slot result: valid result (+4 on link), else csr, else divider
    function automatic logic [xlen-1:0] ref_slot_data(slot_t s);
        if (s.result_valid) begin
            return s.uop.is_link ? s.result + 32'd4 : s.result;
        end else if (s.uop.is_csr) begin
            return csr_data;
        end
        return s.uop.div_rem ? remainder : quotient;
    endfunction

    // exception csr state after one commit
    function automatic csr_state_t ref_csr(csr_state_t cur, exc_t e, logic intr);
        csr_state_t nxt;
        nxt = cur;
        if (e.flag || intr) begin
            nxt.era = e.era;
        end
        if (e.flag && e.ecode inside {ecode_pil, ecode_pis, ecode_pif, ecode_pme, ecode_ppi,
                ecode_tlbr}) begin
            nxt.vppn = e.badv[vppn_w-1:0];
        end
        if (e.flag && e.ecode inside {ecode_pil, ecode_pis, ecode_pif, ecode_pme, ecode_ppi,
                ecode_adef, ecode_ale, ecode_tlbr}) begin
            nxt.badv = e.badv;
        end
        return nxt;
    endfunction

    function automatic slot_t alu_slot(logic [reg_addr_w-1:0] rd);
        slot_t s;
        s = '0;
        s.rd = rd;
        s.result = $urandom();
        s.result_valid = 1'b1;
        s.uop.is_link = 1'($urandom_range(1));
        return s;
    endfunction

    task automatic stop_run(string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    // r0 reads zero; readable two edges after the write cycle
    task automatic expect_reg(logic [reg_addr_w-1:0] rd, logic [xlen-1:0] data);
        chk_q.push_back('{addr: rd, data: (rd == '0) ? xlen'(0) : data, due: cyc + 2});
    endtask

    task automatic expect_stall(int cycles);
        repeat (cycles) begin
            #1;
            assert (!allowin) else
                stop_run($sformatf("FAILED at %0t: allowin high during a stall", $time));
            step();
        end
    endtask

    task automatic wait_allowin(int limit);
        int n;
        n = 0;
        #1;
        while (!allowin) begin
            if (n == limit) begin
                stop_run("timeout while waiting for allowin to rise");
            end
            step();
            #1;
            n++;
        end
    endtask

    // compare process, reads each register on both ports when it is due
    initial begin
        chk_t c;
        cyc = 0;
        rd_addr0 = '0;
        rd_addr1 = '0;
        forever begin
            @(posedge clk);
            cyc++;
            #5;
            while (chk_q.size() != 0 && chk_q[0].due == cyc) begin
                c = chk_q.pop_front();
                rd_addr0 = c.addr;
                rd_addr1 = c.addr;
                #1;
                assert (rd_data0 == c.data && rd_data1 == c.data) else
                    stop_run($sformatf("FAILED at %0t: r%0d read %h/%h, expected %h",
                        $time, c.addr, rd_data0, rd_data1, c.data));
            end
        end
    end

    initial begin
        slot_t                 sl;
        logic [reg_addr_w-1:0] rd;
        logic                  intr;
        int                    code_base;
        void'($urandom(61));
        aresetn = 1'b0;
        slot0 = '0;
        slot1 = '0;
        exc = '0;
        quotient = '0;
        remainder = '0;
        csr_data = '0;
        dcache_data = '0;
        dcache_rd = '0;
        cfg_data = '0;
        div_ready = 1'b0;
        csr_ready = 1'b0;
        dcache_ready = 1'b0;
        cpu_interrupt = 1'b0;
        cfg_we = 1'b0;
        cfg_sel = 1'b0;
        csr_model = '0;
        repeat (5) @(posedge clk);
        #5;
        aresetn = 1'b1;
        eentry_v = $urandom();
        tlbr_v = $urandom();
        step();
        cfg_we = 1'b1;
        cfg_data = eentry_v;
        step();
        cfg_sel = 1'b1;
        cfg_data = tlbr_v;
        step();
        cfg_we = 1'b0;

        // dual alu writes, slot 1 wins on a shared rd
        repeat (40) begin
            step();
            rd = ($urandom_range(7) == 0) ? '0 : 5'($urandom_range(31, 1));
            slot0 = alu_slot(rd);
            slot1 = alu_slot(($urandom_range(3) == 0) ? rd : 5'($urandom_range(31)));
            if (slot0.rd != slot1.rd) begin
                expect_reg(slot0.rd, ref_slot_data(slot0));
            end
            expect_reg(slot1.rd, ref_slot_data(slot1));
        end

        // divide in slot 0, divide in slot 1, csr read in slot 0
        for (int i = 0; i < 9; i++) begin
            step();
            sl = '0;
            sl.rd = 5'($urandom_range(31, 1));
            sl.uop.is_csr = (i % 3 == 2);
            sl.uop.is_div = (i % 3 != 2);
            sl.uop.div_rem = 1'($urandom_range(1));
            slot0 = (i % 3 == 1) ? '0 : sl;
            slot1 = (i % 3 == 1) ? sl : '0;
            expect_stall($urandom_range(4, 1));
            quotient = $urandom();
            remainder = $urandom();
            csr_data = $urandom();
            div_ready = sl.uop.is_div;
            csr_ready = sl.uop.is_csr;
            expect_reg(sl.rd, ref_slot_data(sl));
            wait_allowin(4);
            step();
            div_ready = 1'b0;
            csr_ready = 1'b0;
            slot0 = '0;
            slot1 = '0;
        end

        // loads; cache data beats a slot write to the same register
        repeat (4) begin
            step();
            slot0.uop.is_load = 1'b1;
            step();
            slot0 = '0;
            expect_stall($urandom_range(5, 1));
            rd = 5'($urandom_range(31, 1));
            dcache_rd = rd;
            dcache_data = $urandom();
            dcache_ready = 1'b1;
            slot0 = alu_slot(rd);
            expect_reg(rd, dcache_data);
            wait_allowin(4);
            step();
            dcache_ready = 1'b0;
            slot0 = '0;
        end

        // exceptions, every fourth one an interrupt instead
        code_base = $urandom_range(9);
        for (int i = 0; i < 16; i++) begin
            step();
            intr = (i % 4 == 3);
            exc.flag = !intr;
            // the twelve exceptions walk all ten codes from a random start
            exc.ecode = codes[(code_base + i - i / 4) % 10];
            exc.badv = $urandom();
            exc.era = $urandom();
            cpu_interrupt = intr;
            csr_model = ref_csr(csr_model, exc, intr);
            target = (exc.flag && exc.ecode == ecode_tlbr) ? tlbr_v : eentry_v;
            step();
            exc.flag = 1'b0;
            cpu_interrupt = 1'b0;
            #1;
            assert (flush && redirect_pc == target) else
                stop_run($sformatf("FAILED at %0t: flush %b redirect %h, expected %h",
                    $time, flush, redirect_pc, target));
            step();
            #1;
            assert ({era, badv, vppn} == csr_model) else
                stop_run($sformatf("FAILED at %0t: era %h badv %h vppn %h, expected %h",
                    $time, era, badv, vppn, csr_model));
        end

        repeat (3) step();
        if (chk_q.size() != 0) begin
            stop_run("register reads were still waiting at the end of the run");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* src/wb_top.sv */
`timescale 1ns/1ps
module wb_top (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::slot_t                 slot0,
    input  wb_pkg::slot_t                 slot1,
    input  logic [wb_pkg::xlen-1:0]       quotient,
    input  logic [wb_pkg::xlen-1:0]       remainder,
    input  logic                          div_ready,
    input  logic [wb_pkg::xlen-1:0]       csr_data,
    input  logic                          csr_ready,
    input  logic [wb_pkg::xlen-1:0]       dcache_data,
    input  logic [wb_pkg::reg_addr_w-1:0] dcache_rd,
    input  logic                          dcache_ready,
    input  wb_pkg::exc_t                  exc,
    input  logic                          cpu_interrupt,
    input  logic                          cfg_we,
    input  logic                          cfg_sel,
    input  logic [wb_pkg::xlen-1:0]       cfg_data,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr0,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr1,
    output logic                          allowin,
    output logic [wb_pkg::xlen-1:0]       rd_data0,
    output logic [wb_pkg::xlen-1:0]       rd_data1,
    output logic                          flush,
    output logic [wb_pkg::xlen-1:0]       redirect_pc,
    output logic [wb_pkg::xlen-1:0]       era,
    output logic [wb_pkg::xlen-1:0]       badv,
    output logic [wb_pkg::vppn_w-1:0]     vppn
);
    import wb_pkg::*;

    wb_port_t        wb0;
    wb_port_t        wb1;
    wb_port_t        wb2;
    csr_wr_t         csr_wr;
    logic [xlen-1:0] eentry;
    logic [xlen-1:0] tlbrentry;

    ex2_wb_stage u_stage (
        .clk, .aresetn, .slot0, .slot1, .quotient, .remainder, .div_ready,
        .csr_data, .csr_ready, .dcache_data, .dcache_rd, .dcache_ready,
        .allowin, .wb0, .wb1, .wb2
    );

    reg_file u_rf (
        .clk, .aresetn, .wb0, .wb1, .wb2,
        .rd_addr0, .rd_addr1, .rd_data0, .rd_data1
    );

    exc_commit u_commit (
        .clk, .aresetn, .exc, .cpu_interrupt, .eentry, .tlbrentry,
        .flush, .redirect_pc, .csr_wr
    );

    exc_csr_regs u_csr (
        .clk, .aresetn, .csr_wr, .cfg_we, .cfg_sel, .cfg_data,
        .era, .badv, .vppn, .eentry, .tlbrentry
    );

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps
module reg_file (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::wb_port_t              wb0,
    input  wb_pkg::wb_port_t              wb1,
    input  wb_pkg::wb_port_t              wb2,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr0,
    input  logic [wb_pkg::reg_addr_w-1:0] rd_addr1,
    output logic [wb_pkg::xlen-1:0]       rd_data0,
    output logic [wb_pkg::xlen-1:0]       rd_data1
);
    import wb_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    // later port wins on the same index
    always_ff @(posedge clk) begin
        if (wb0.we) begin
            regs[wb0.rd] <= wb0.data;
        end
        if (wb1.we) begin
            regs[wb1.rd] <= wb1.data;
        end
        if (wb2.we) begin
            regs[wb2.rd] <= wb2.data;
        end
    end

    // r0 reads zero whatever was stored
    assign rd_data0 = (rd_addr0 == '0) ? '0 : regs[rd_addr0];
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];

endmodule

/* src/exc_csr_regs.sv */
`timescale 1ns/1ps
module exc_csr_regs (
    input  logic                      clk,
    input  logic                      aresetn,
    input  wb_pkg::csr_wr_t           csr_wr,
    input  logic                      cfg_we,
    input  logic                      cfg_sel,
    input  logic [wb_pkg::xlen-1:0]   cfg_data,
    output logic [wb_pkg::xlen-1:0]   era,
    output logic [wb_pkg::xlen-1:0]   badv,
    output logic [wb_pkg::vppn_w-1:0] vppn,
    output logic [wb_pkg::xlen-1:0]   eentry,
    output logic [wb_pkg::xlen-1:0]   tlbrentry
);
    import wb_pkg::*;

    // exception state, written by commit
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            era  <= '0;
            badv <= '0;
            vppn <= '0;
        end else begin
            if (csr_wr.we_era) begin
                era <= csr_wr.era;
            end
            if (csr_wr.we_badv) begin
                badv <= csr_wr.badv;
            end
            if (csr_wr.we_vppn) begin
                vppn <= csr_wr.vppn;
            end
        end
    end

    // entry addresses, set by software
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            eentry    <= '0;
            tlbrentry <= '0;
        end else if (cfg_we) begin
            if (cfg_sel) begin
                tlbrentry <= cfg_data;
            end else begin
                eentry <= cfg_data;
            end
        end
    end

    // vppn comes with badv, from its low bits
    a_vppn_from_badv: assert property (
        @(posedge clk) disable iff (!aresetn)
        csr_wr.we_vppn |-> (csr_wr.we_badv && csr_wr.vppn == csr_wr.badv[vppn_w-1:0])
    );

endmodule

/* src/exc_commit.sv */
`timescale 1ns/1ps
module exc_commit (
    input  logic                    clk,
    input  logic                    aresetn,
    input  wb_pkg::exc_t            exc,
    input  logic                    cpu_interrupt,
    input  logic [wb_pkg::xlen-1:0] eentry,
    input  logic [wb_pkg::xlen-1:0] tlbrentry,
    output logic                    flush,
    output logic [wb_pkg::xlen-1:0] redirect_pc,
    output wb_pkg::csr_wr_t         csr_wr
);
    import wb_pkg::*;

    logic              set_badv;
    logic              set_vppn;
    logic              flush_q;
    logic              we_badv_q;
    logic              we_vppn_q;
    logic              tlbr_q;
    logic [xlen-1:0]   era_q;
    logic [xlen-1:0]   badv_q;
    logic [vppn_w-1:0] vppn_q;

    // address faults record badv; only tlb faults record vppn
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (exc.ecode)
            ecode_pil, ecode_pis, ecode_pif, ecode_pme, ecode_ppi, ecode_tlbr: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            ecode_adef, ecode_ale: begin
                set_badv = 1'b1;
            end
            default: begin
                set_badv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush_q   <= 1'b0;
            we_badv_q <= 1'b0;
            we_vppn_q <= 1'b0;
            tlbr_q    <= 1'b0;
        end else begin
            flush_q   <= exc.flag || cpu_interrupt;
            we_badv_q <= exc.flag && set_badv;
            we_vppn_q <= exc.flag && set_vppn;
            tlbr_q    <= exc.flag && (exc.ecode == ecode_tlbr);
        end
    end

    always_ff @(posedge clk) begin
        era_q  <= exc.era;
        badv_q <= exc.badv;
        vppn_q <= exc.badv[vppn_w-1:0];
    end

    assign flush       = flush_q;
    assign redirect_pc = tlbr_q ? tlbrentry : eentry;
    // era is written on every flush, interrupts included
    assign csr_wr = '{we_era: flush_q, era: era_q,
                      we_badv: we_badv_q, badv: badv_q,
                      we_vppn: we_vppn_q, vppn: vppn_q};

    a_badv_needs_flush: assert property (
        @(posedge clk) disable iff (!aresetn)
        (csr_wr.we_badv || csr_wr.we_vppn) |-> flush
    );

endmodule

/* src/ex2_wb_stage.sv */
`timescale 1ns/1ps
module ex2_wb_stage (
    input  logic                          clk,
    input  logic                          aresetn,
    input  wb_pkg::slot_t                 slot0,
    input  wb_pkg::slot_t                 slot1,
    input  logic [wb_pkg::xlen-1:0]       quotient,
    input  logic [wb_pkg::xlen-1:0]       remainder,
    input  logic                          div_ready,
    input  logic [wb_pkg::xlen-1:0]       csr_data,
    input  logic                          csr_ready,
    input  logic [wb_pkg::xlen-1:0]       dcache_data,
    input  logic [wb_pkg::reg_addr_w-1:0] dcache_rd,
    input  logic                          dcache_ready,
    output logic                          allowin,
    output wb_pkg::wb_port_t              wb0,
    output wb_pkg::wb_port_t              wb1,
    output wb_pkg::wb_port_t              wb2
);
    import wb_pkg::*;

    wb_port_t              wb0_d;
    wb_port_t              wb1_d;
    logic                  load_pending;
    logic                  div_wait;
    logic                  csr_wait;
    logic                  load_wait;
    logic [2:0]            we_q;
    logic [reg_addr_w-1:0] rd_q [3];
    logic [xlen-1:0]       data_q [3];

    // priority: plain result, then csr read, then divider
    function automatic wb_port_t pick(slot_t s, logic csr_en);
        wb_port_t p;
        p.we   = 1'b0;
        p.rd   = s.rd;
        p.data = s.result;
        if (s.result_valid) begin
            p.we = 1'b1;
            if (s.uop.is_link) begin
                p.data = s.result + xlen'(4);
            end
        end else if (csr_en && s.uop.is_csr) begin
            p.we   = csr_ready;
            p.data = csr_data;
        end else if (s.uop.is_div) begin
            p.we   = div_ready;
            p.data = s.uop.div_rem ? remainder : quotient;
        end
        return p;
    endfunction

    always_comb begin
        wb0_d = pick(slot0, 1'b1);
        // no csr path on slot 1
        wb1_d = pick(slot1, 1'b0);
    end

    // hold upstream until every pending source has answered
    assign div_wait  = (slot0.uop.is_div || slot1.uop.is_div) && !div_ready;
    assign csr_wait  = slot0.uop.is_csr && !csr_ready;
    assign load_wait = load_pending && !dcache_ready;
    assign allowin   = !(div_wait || csr_wait || load_wait);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            load_pending <= 1'b0;
        end else if (load_pending) begin
            if (dcache_ready) begin
                load_pending <= 1'b0;
            end
        end else if (slot0.uop.is_load && allowin && !dcache_ready) begin
            // a same-cycle answer never opens a wait
            load_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            we_q <= '0;
        end else begin
            we_q <= {dcache_ready, wb1_d.we, wb0_d.we};
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0]   <= wb0_d.rd;
        data_q[0] <= wb0_d.data;
        rd_q[1]   <= wb1_d.rd;
        data_q[1] <= wb1_d.data;
        // load data, rd comes from the cache
        rd_q[2]   <= dcache_rd;
        data_q[2] <= dcache_data;
    end

    assign wb0 = '{we: we_q[0], rd: rd_q[0], data: data_q[0]};
    assign wb1 = '{we: we_q[1], rd: rd_q[1], data: data_q[1]};
    assign wb2 = '{we: we_q[2], rd: rd_q[2], data: data_q[2]};

    a_slot0_one_kind: assert property (
        @(posedge clk) disable iff (!aresetn)
        $onehot0({slot0.uop.is_csr, slot0.uop.is_div, slot0.uop.is_load})
    );

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int vppn_w     = 19;

    // LoongArch ecode values
    typedef enum logic [6:0] {
        ecode_int  = 7'h00,
        ecode_pil  = 7'h01,
        ecode_pis  = 7'h02,
        ecode_pif  = 7'h03,
        ecode_pme  = 7'h04,
        ecode_ppi  = 7'h07,
        ecode_adef = 7'h08,
        ecode_ale  = 7'h09,
        ecode_sys  = 7'h0b,
        ecode_tlbr = 7'h3f
    } ecode_e;

    typedef struct packed {
        logic is_csr;
        logic is_div;
        logic div_rem;
        logic is_load;
        logic is_link;
    } uop_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        uop_t                  uop;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  result_valid;
    } slot_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } wb_port_t;

    typedef struct packed {
        logic            flag;
        ecode_e          ecode;
        logic [xlen-1:0] badv;
        logic [xlen-1:0] era;
    } exc_t;

    typedef struct packed {
        logic              we_era;
        logic [xlen-1:0]   era;
        logic              we_badv;
        logic [xlen-1:0]   badv;
        logic              we_vppn;
        logic [vppn_w-1:0] vppn;
    } csr_wr_t;

endpackage
